// File: cpuIsaPkg.sv
package cpuIsaPkg;

        localparam int dataWidth = 32;
        localparam int opcodeWidth = 5;
        localparam int fieldWidth = 4;
        localparam int shamtWidth = $clog2(dataWidth);

        // Instruction word field positions.
        localparam int opcodeMsb = 31;
        localparam int raMsb = 26;
        localparam int rbMsb = 22;
        localparam int rcMsb = 18;
        localparam int constWidth = 19; // Constant sits in bits 18..0.

        typedef enum logic [opcodeWidth-1:0] {
                ldi = 5'b00001,
                add = 5'b00011,
                sub = 5'b00100,
                andOp = 5'b00101,
                orOp = 5'b00110,
                shr = 5'b01001,
                shra = 5'b01010,
                shl = 5'b01011,
                ror = 5'b01100,
                rol = 5'b01101
        } opcodeT;

        typedef enum logic [3:0] {
                aluPass,        // Operand B straight through, for ldi.
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluShr,
                aluShra,
                aluShl,
                aluRor,
                aluRol
        } aluOpT;

endpackage

// File: cpuPipePkg.sv
package cpuPipePkg;

        import cpuIsaPkg::*;

        localparam int regCount = 16;
        localparam int regAddrWidth = 4;

        // Decode to execute.
        typedef struct packed {
                aluOpT aluOp;
                logic [regAddrWidth-1:0] dest;
                logic [dataWidth-1:0] opA;
                logic [dataWidth-1:0] opB;
                logic illegal;
        } decodedT;

        // Execute to writeback.
        typedef struct packed {
                logic [regAddrWidth-1:0] dest;
                logic [dataWidth-1:0] value;
                logic writeEn;
                logic illegal;
        } resultT;

endpackage

// File: stageLink.sv
interface stageLink #(
        parameter type payloadT = logic [31:0]
);

        logic req;
        logic ack;
        payloadT payload; // Held stable while req is high.

        modport sender (
                output req,
                output payload,
                input ack
        );

        modport receiver (
                input req,
                input payload,
                output ack
        );

endinterface

// File: instrReceiver.sv
module instrReceiver
        import cpuIsaPkg::*;
(
        input  logic Clock,
        input  logic rst,
        input  logic instrReq,
        input  logic [dataWidth-1:0] instrData,
        output logic instrAck,
        stageLink.sender outLink
);

        logic full;
        logic take;

        // Accept only with the internal link fully idle.
        assign take = instrReq && !instrAck && !full && !outLink.ack;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        instrAck <= 1'b0;
                        outLink.req <= 1'b0;
                        full <= 1'b0;
                end else begin
                        if (take) begin
                                instrAck <= 1'b1;
                                full <= 1'b1;
                        end else if (instrAck && !instrReq) begin
                                instrAck <= 1'b0;
                        end
                        if (full && !outLink.req && !outLink.ack) begin
                                outLink.req <= 1'b1;
                        end else if (outLink.req && outLink.ack) begin
                                outLink.req <= 1'b0; // Word released once taken.
                                full <= 1'b0;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (take) begin
                        outLink.payload <= instrData;
                end
        end

endmodule

// File: registerFile.sv
module registerFile
        import cpuIsaPkg::*;
        import cpuPipePkg::*;
(
        input  logic Clock,
        input  logic rst,
        input  logic [regAddrWidth-1:0] readAddrA,
        input  logic [regAddrWidth-1:0] readAddrB,
        output logic [dataWidth-1:0] readDataA,
        output logic [dataWidth-1:0] readDataB,
        output logic pendingA,
        output logic pendingB,
        output logic pendingDest,
        input  logic [regAddrWidth-1:0] checkDest,
        input  logic setPending,
        input  logic [regAddrWidth-1:0] setAddr,
        input  logic writeEn,
        input  logic [regAddrWidth-1:0] writeAddr,
        input  logic [dataWidth-1:0] writeData
);

        logic [dataWidth-1:0] regs [regCount];
        logic [regCount-1:0] pending;
        logic hitA;
        logic hitB;
        logic hitDest;

        assign hitA = writeEn && (writeAddr == readAddrA);
        assign hitB = writeEn && (writeAddr == readAddrB);
        assign hitDest = writeEn && (writeAddr == checkDest);

        // Write bypass on data and on the pending bits.
        assign readDataA = hitA ? writeData : regs[readAddrA];
        assign readDataB = hitB ? writeData : regs[readAddrB];
        assign pendingA = pending[readAddrA] && !hitA;
        assign pendingB = pending[readAddrB] && !hitB;
        assign pendingDest = pending[checkDest] && !hitDest;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEn) begin
                        regs[writeAddr] <= writeData;
                end
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        pending <= '0;
                end else begin
                        if (writeEn) begin
                                pending[writeAddr] <= 1'b0;
                        end
                        if (setPending) begin
                                pending[setAddr] <= 1'b1; // Set wins over clear.
                        end
                end
        end

endmodule

// File: decodeStage.sv
module decodeStage
        import cpuIsaPkg::*;
        import cpuPipePkg::*;
(
        input  logic Clock,
        input  logic rst,
        stageLink.receiver inLink,
        stageLink.sender outLink,
        output logic [regAddrWidth-1:0] readAddrA,
        output logic [regAddrWidth-1:0] readAddrB,
        output logic [regAddrWidth-1:0] checkDest,
        input  logic [dataWidth-1:0] readDataA,
        input  logic [dataWidth-1:0] readDataB,
        input  logic pendingA,
        input  logic pendingB,
        input  logic pendingDest,
        output logic setPending,
        output logic [regAddrWidth-1:0] setAddr
);

        logic [dataWidth-1:0] word;
        opcodeT opcode;
        aluOpT aluOp;
        logic legal;
        logic useSrc;
        logic hazard;
        logic take;
        logic full;
        logic [dataWidth-1:0] immediate;
        decodedT item;

        assign word = inLink.payload;
        assign opcode = opcodeT'(word[opcodeMsb -: opcodeWidth]);
        assign checkDest = word[raMsb -: fieldWidth];
        assign readAddrA = word[rbMsb -: fieldWidth];
        assign readAddrB = word[rcMsb -: fieldWidth];
        assign immediate = {{(dataWidth-constWidth){word[constWidth-1]}}, word[constWidth-1:0]};

        always_comb begin
                legal = 1'b1;
                case (opcode)
                        ldi: aluOp = aluPass;
                        add: aluOp = aluAdd;
                        sub: aluOp = aluSub;
                        andOp: aluOp = aluAnd;
                        orOp: aluOp = aluOr;
                        shr: aluOp = aluShr;
                        shra: aluOp = aluShra;
                        shl: aluOp = aluShl;
                        ror: aluOp = aluRor;
                        rol: aluOp = aluRol;
                        default: begin
                                aluOp = aluPass;
                                legal = 1'b0;
                        end
                endcase
        end

        // ldi has no register sources; its Rb/Rc bits are constant bits.
        assign useSrc = legal && (opcode != ldi);
        assign hazard = legal && (pendingDest || (useSrc && (pendingA || pendingB)));
        assign take = inLink.req && !inLink.ack && !full && !hazard;

        assign setPending = take && legal;
        assign setAddr = checkDest;

        always_comb begin
                item.aluOp = aluOp;
                item.dest = checkDest;
                item.opA = readDataA;
                item.opB = (opcode == ldi) ? immediate : readDataB;
                item.illegal = !legal;
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        inLink.ack <= 1'b0;
                        outLink.req <= 1'b0;
                        full <= 1'b0;
                end else begin
                        if (take) begin
                                inLink.ack <= 1'b1;
                                full <= 1'b1;
                        end else if (inLink.ack && !inLink.req) begin
                                inLink.ack <= 1'b0;
                        end
                        if (full && !outLink.req && !outLink.ack) begin
                                outLink.req <= 1'b1;
                        end else if (outLink.req && outLink.ack) begin
                                outLink.req <= 1'b0;
                                full <= 1'b0;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (take) begin
                        outLink.payload <= item;
                end
        end

endmodule

// File: executeStage.sv
module executeStage
        import cpuIsaPkg::*;
        import cpuPipePkg::*;
(
        input  logic Clock,
        input  logic rst,
        stageLink.receiver inLink,
        stageLink.sender outLink
);

        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [shamtWidth-1:0] shamt;
        logic [2*dataWidth-1:0] rotRight;
        logic [2*dataWidth-1:0] rotLeft;
        logic [dataWidth-1:0] value;
        logic take;
        logic full;
        resultT result;

        assign a = inLink.payload.opA;
        assign b = inLink.payload.opB;
        assign shamt = b[shamtWidth-1:0]; // Low five bits only.
        assign rotRight = {a, a} >> shamt;
        assign rotLeft = {a, a} << shamt;

        always_comb begin
                case (inLink.payload.aluOp)
                        aluPass: value = b;
                        aluAdd: value = a + b;
                        aluSub: value = a - b;
                        aluAnd: value = a & b;
                        aluOr: value = a | b;
                        aluShr: value = a >> shamt;
                        aluShra: value = $signed(a) >>> shamt;
                        aluShl: value = a << shamt;
                        aluRor: value = rotRight[dataWidth-1:0];
                        aluRol: value = rotLeft[2*dataWidth-1 -: dataWidth];
                        default: value = '0;
                endcase
        end

        always_comb begin
                result.dest = inLink.payload.dest;
                result.value = value;
                result.writeEn = !inLink.payload.illegal;
                result.illegal = inLink.payload.illegal;
        end

        assign take = inLink.req && !inLink.ack && !full;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        inLink.ack <= 1'b0;
                        outLink.req <= 1'b0;
                        full <= 1'b0;
                end else begin
                        if (take) begin
                                inLink.ack <= 1'b1;
                                full <= 1'b1;
                        end else if (inLink.ack && !inLink.req) begin
                                inLink.ack <= 1'b0;
                        end
                        if (full && !outLink.req && !outLink.ack) begin
                                outLink.req <= 1'b1;
                        end else if (outLink.req && outLink.ack) begin
                                outLink.req <= 1'b0;
                                full <= 1'b0;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (take) begin
                        outLink.payload <= result;
                end
        end

endmodule

// File: writebackStage.sv
module writebackStage
        import cpuIsaPkg::*;
        import cpuPipePkg::*;
(
        input  logic Clock,
        input  logic rst,
        stageLink.receiver inLink,
        output logic writeEn,
        output logic [regAddrWidth-1:0] writeAddr,
        output logic [dataWidth-1:0] writeData,
        output logic resultValid,
        output logic [regAddrWidth-1:0] resultReg,
        output logic [dataWidth-1:0] resultData,
        output logic illegal
);

        resultT item;
        logic take;
        logic valid;
        logic enable;
        logic flag;

        assign take = inLink.req && !inLink.ack; // Never back-pressured.

        assign writeEn = enable;
        assign writeAddr = item.dest;
        assign writeData = item.value;
        assign resultValid = valid;
        assign resultReg = item.dest;
        assign resultData = item.value;
        assign illegal = flag;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        inLink.ack <= 1'b0;
                        valid <= 1'b0;
                        enable <= 1'b0;
                        flag <= 1'b0;
                end else begin
                        valid <= take; // One-cycle pulse per item.
                        enable <= take && inLink.payload.writeEn;
                        flag <= take && inLink.payload.illegal;
                        if (take) begin
                                inLink.ack <= 1'b1;
                        end else if (inLink.ack && !inLink.req) begin
                                inLink.ack <= 1'b0;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (take) begin
                        item <= inLink.payload;
                end
        end

endmodule

// File: datapathTop.sv
module datapathTop
        import cpuIsaPkg::*;
        import cpuPipePkg::*;
(
        input  logic Clock,
        input  logic rst,
        input  logic instrReq,
        input  logic [dataWidth-1:0] instrData,
        output logic instrAck,
        output logic resultValid,
        output logic [regAddrWidth-1:0] resultReg,
        output logic [dataWidth-1:0] resultData,
        output logic illegal
);

        logic [regAddrWidth-1:0] readAddrA;
        logic [regAddrWidth-1:0] readAddrB;
        logic [regAddrWidth-1:0] checkDest;
        logic [dataWidth-1:0] readDataA;
        logic [dataWidth-1:0] readDataB;
        logic pendingA;
        logic pendingB;
        logic pendingDest;
        logic setPending;
        logic [regAddrWidth-1:0] setAddr;
        logic writeEn;
        logic [regAddrWidth-1:0] writeAddr;
        logic [dataWidth-1:0] writeData;

        stageLink #(.payloadT(logic [dataWidth-1:0])) instrLink ();
        stageLink #(.payloadT(decodedT)) decodeLink ();
        stageLink #(.payloadT(resultT)) resultLink ();

        instrReceiver i_instrReceiver (
                .Clock(Clock),
                .rst(rst),
                .instrReq(instrReq),
                .instrData(instrData),
                .instrAck(instrAck),
                .outLink(instrLink.sender)
        );

        decodeStage i_decodeStage (
                .Clock(Clock),
                .rst(rst),
                .inLink(instrLink.receiver),
                .outLink(decodeLink.sender),
                .readAddrA(readAddrA),
                .readAddrB(readAddrB),
                .checkDest(checkDest),
                .readDataA(readDataA),
                .readDataB(readDataB),
                .pendingA(pendingA),
                .pendingB(pendingB),
                .pendingDest(pendingDest),
                .setPending(setPending),
                .setAddr(setAddr)
        );

        executeStage i_executeStage (
                .Clock(Clock),
                .rst(rst),
                .inLink(decodeLink.receiver),
                .outLink(resultLink.sender)
        );

        writebackStage i_writebackStage (
                .Clock(Clock),
                .rst(rst),
                .inLink(resultLink.receiver),
                .writeEn(writeEn),
                .writeAddr(writeAddr),
                .writeData(writeData),
                .resultValid(resultValid),
                .resultReg(resultReg),
                .resultData(resultData),
                .illegal(illegal)
        );

        registerFile i_registerFile (
                .Clock(Clock),
                .rst(rst),
                .readAddrA(readAddrA),
                .readAddrB(readAddrB),
                .readDataA(readDataA),
                .readDataB(readDataB),
                .pendingA(pendingA),
                .pendingB(pendingB),
                .pendingDest(pendingDest),
                .checkDest(checkDest),
                .setPending(setPending),
                .setAddr(setAddr),
                .writeEn(writeEn),
                .writeAddr(writeAddr),
                .writeData(writeData)
        );

endmodule

// File: datapath_assertions.sv
module datapathAssertions
        import cpuIsaPkg::*;
(
        input logic Clock,
        input logic rst,
        input logic instrReq,
        input logic [dataWidth-1:0] instrData,
        input logic instrAck,
        input logic resultValid,
        input logic illegal
);
        timeunit 1ns;
        timeprecision 100ps;

        int failCount = 0;

        ackAfterReq: assert property (@(posedge Clock) disable iff (rst)
                $rose(instrAck) |-> instrReq)
                else begin
                        failCount++;
                        $error("instrAck rose while instrReq was low");
                end

        dataStable: assert property (@(posedge Clock) disable iff (rst)
                (instrReq && !instrAck) |=> $stable(instrData))
                else begin
                        failCount++;
                        $error("instrData changed before instrAck");
                end

        // Writeback never accepts two items on adjacent cycles.
        singlePulse: assert property (@(posedge Clock) disable iff (rst)
                resultValid |=> !resultValid)
                else begin
                        failCount++;
                        $error("resultValid held longer than one cycle");
                end

        illegalQualified: assert property (@(posedge Clock) disable iff (rst)
                illegal |-> resultValid)
                else begin
                        failCount++;
                        $error("illegal high without resultValid");
                end

endmodule

bind datapathTop datapathAssertions i_datapathAssertions (.*);

// File: datapathTb.sv
module datapathTb
        import cpuIsaPkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        typedef struct packed {
                logic [dataWidth-1:0] word;
                logic [3:0] dest;
                logic [dataWidth-1:0] value;
                logic illegal;
                logic valueKnown; // Illegal words carry no defined value.
                logic [2:0] testId;
        } entryT;

        logic Clock;
        logic rst;
        logic instrReq;
        logic [dataWidth-1:0] instrData;
        logic instrAck;
        logic resultValid;
        logic [3:0] resultReg;
        logic [dataWidth-1:0] resultData;
        logic illegal;

        entryT stimTable[$];
        logic [dataWidth-1:0] shadow [16];
        logic [15:0] lfsrState;
        logic tableReady;
        int checkedCount;
        int checkCount;
        int errorCount;
        int testsFailed;
        int assertErrors;
        logic [4:0] aluOps [9] = '{add, sub, andOp, orOp, shr, shra, shl, ror, rol};

        datapathTop i_datapathTop (
                .Clock(Clock),
                .rst(rst),
                .instrReq(instrReq),
                .instrData(instrData),
                .instrAck(instrAck),
                .resultValid(resultValid),
                .resultReg(resultReg),
                .resultData(resultData),
                .illegal(illegal)
        );

        initial begin
                Clock = 1'b0;
                forever #5 Clock = ~Clock;
        end

        function automatic logic [31:0] regOp(input logic [4:0] op, input int ra, input int rb,
                                              input int rc);
                return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
        endfunction

        function automatic logic [31:0] immOp(input int ra, input logic [18:0] constant);
                return {ldi, ra[3:0], 4'd0, constant};
        endfunction

        function automatic logic isKnownOp(input logic [4:0] op);
                case (op)
                        ldi, add, sub, andOp, orOp, shr, shra, shl, ror, rol: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

        // One bit position per step, so shifts and rotates follow the ISA text directly.
        function automatic logic [31:0] aluModel(input logic [4:0] op, input logic [31:0] a,
                                                 input logic [31:0] b);
                logic [31:0] r;
                int amount;
                r = a;
                amount = b[4:0];
                case (op)
                        ldi: r = b;
                        add: r = a + b;
                        sub: r = a - b;
                        andOp: r = a & b;
                        orOp: r = a | b;
                        shr: repeat (amount) r = {1'b0, r[31:1]};
                        shra: repeat (amount) r = {r[31], r[31:1]};
                        shl: repeat (amount) r = {r[30:0], 1'b0};
                        ror: repeat (amount) r = {r[0], r[31:1]};
                        rol: repeat (amount) r = {r[30:0], r[31]};
                        default: r = '0;
                endcase
                return r;
        endfunction

        // Fibonacci LFSR, taps 16 14 13 11.
        function automatic logic [31:0] takeBits(input int count);
                logic [31:0] bits;
                logic feedback;
                bits = '0;
                for (int i = 0; i < count; i++) begin
                        feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
                        lfsrState = {lfsrState[14:0], feedback};
                        bits = {bits[30:0], feedback};
                end
                return bits;
        endfunction

        task automatic addEntry(input int testId, input logic [31:0] word);
                entryT e;
                logic [4:0] op;
                logic [31:0] b;
                op = word[31:27];
                e.word = word;
                e.dest = word[26:23];
                e.testId = testId;
                e.illegal = !isKnownOp(op);
                e.valueKnown = !e.illegal;
                e.value = '0;
                if (!e.illegal) begin
                        if (op == ldi)
                                b = {{13{word[18]}}, word[18:0]};
                        else
                                b = shadow[word[18:15]];
                        e.value = aluModel(op, shadow[word[22:19]], b);
                        shadow[e.dest] = e.value;
                end
                stimTable.push_back(e);
        endtask

        task automatic buildTable();
                int k;
                for (k = 0; k < 16; k++) shadow[k] = '0;
                lfsrState = 16'd93;
                addEntry(1, immOp(4, 19'h12));
                addEntry(1, immOp(3, 19'h7F));
                addEntry(1, immOp(7, 19'h1));
                addEntry(1, immOp(9, 19'h7EDCC)); // -0x1234.
                addEntry(2, regOp(shr, 4, 3, 7)); // Gives 0x3F.
                addEntry(2, regOp(shra, 5, 9, 7));
                addEntry(2, regOp(shl, 6, 3, 7));
                addEntry(3, immOp(14, 19'h24)); // Low five bits give 4.
                addEntry(3, regOp(add, 8, 3, 4));
                addEntry(3, regOp(sub, 10, 4, 3));
                addEntry(3, regOp(andOp, 11, 3, 9));
                addEntry(3, regOp(orOp, 12, 4, 9));
                addEntry(3, regOp(ror, 13, 9, 14));
                addEntry(3, regOp(rol, 15, 9, 14));
                addEntry(3, regOp(ror, 13, 13, 7));
                addEntry(4, regOp(add, 1, 3, 4)); // Each reads the previous destination.
                addEntry(4, regOp(add, 1, 1, 3));
                addEntry(4, regOp(sub, 2, 1, 4));
                addEntry(4, regOp(shl, 2, 2, 7));
                addEntry(4, regOp(orOp, 1, 2, 1));
                addEntry(4, regOp(rol, 1, 1, 7));
                addEntry(4, regOp(sub, 2, 1, 2));
                addEntry(5, regOp(5'b11111, 8, 1, 2));
                addEntry(5, regOp(orOp, 6, 8, 0)); // R8 must be unchanged.
                addEntry(5, regOp(5'b00000, 3, 3, 3));
                addEntry(5, regOp(add, 5, 3, 0));
                for (k = 0; k < 8; k++) addEntry(6, immOp(k, takeBits(19)));
                for (k = 0; k < 20; k++)
                        addEntry(6, regOp(aluOps[takeBits(4) % 9], takeBits(3), takeBits(3),
                                          takeBits(3)));
        endtask

        task automatic sendWord(input logic [31:0] word);
                instrData <= word;
                instrReq <= 1'b1;
                do @(posedge Clock); while (!instrAck);
                instrReq <= 1'b0;
                do @(posedge Clock); while (instrAck);
        endtask

        task automatic compareValues(input string what, input logic [31:0] got,
                                     input logic [31:0] expected);
                checkCount++;
                if (got !== expected) begin
                        errorCount++;
                        $display("error at %0t ns: %s is %h, expected %h", $time, what, got,
                                 expected);
                end
        endtask

        function automatic string testName(input int id);
                case (id)
                        1: return "ldi sign extension";
                        2: return "shift rules";
                        3: return "arithmetic, logic and rotates";
                        4: return "dependent chain";
                        5: return "unknown opcode";
                        default: return "random ALU sequence";
                endcase
        endfunction

        initial begin : resultChecker
                entryT exp;
                int startErrors;
                startErrors = 0;
                forever begin
                        @(posedge Clock);
                        if (!rst && resultValid) begin
                                if (checkedCount >= stimTable.size()) begin
                                        errorCount++;
                                        $display("Result pulse at %0t ns with no instruction left",
                                                 $time);
                                end else begin
                                        exp = stimTable[checkedCount];
                                        if (checkedCount == 0 ||
                                            stimTable[checkedCount-1].testId != exp.testId)
                                                startErrors = errorCount;
                                        compareValues($sformatf("entry %0d dest", checkedCount),
                                                      resultReg, exp.dest);
                                        compareValues($sformatf("entry %0d illegal", checkedCount),
                                                      illegal, exp.illegal);
                                        if (exp.valueKnown)
                                                compareValues($sformatf("entry %0d data",
                                                              checkedCount), resultData, exp.value);
                                        checkedCount++;
                                        if (checkedCount == stimTable.size() ||
                                            stimTable[checkedCount].testId != exp.testId) begin
                                                if (errorCount != startErrors) testsFailed++;
                                                $display("behavior %0d, %s: %0d mismatches",
                                                         exp.testId, testName(exp.testId),
                                                         errorCount - startErrors);
                                        end
                                end
                        end
                end
        end

        initial begin : watchdog
                wait (tableReady);
                repeat (200 * stimTable.size()) @(posedge Clock);
                $display("Watchdog expired: only %0d of %0d results arrived", checkedCount,
                         stimTable.size());
                $display("Test FAILED");
                $finish;
        end

        initial begin
                rst = 1'b1;
                instrReq = 1'b0;
                instrData = '0;
                tableReady = 1'b0;
                checkedCount = 0;
                checkCount = 0;
                errorCount = 0;
                testsFailed = 0;
                assertErrors = 0;
                buildTable();
                tableReady = 1'b1;
                repeat (2) @(posedge Clock);
                rst <= 1'b0;
                @(posedge Clock);
                foreach (stimTable[i]) sendWord(stimTable[i].word);
                wait (checkedCount == stimTable.size());
                repeat (20) @(posedge Clock); // Catch stray result pulses.
                assertErrors = i_datapathTop.i_datapathAssertions.failCount;
                $display("Failing behaviors %0d, checks %0d, mismatches %0d, assertion errors %0d",
                         testsFailed, checkCount, errorCount, assertErrors);
                if (errorCount == 0 && assertErrors == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

endmodule

// File: list.f
cpuIsaPkg.sv
cpuPipePkg.sv
stageLink.sv
instrReceiver.sv
registerFile.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
datapathTop.sv
datapath_assertions.sv
datapathTb.sv
